//--- verilog/epb_wb_pkg.sv
`default_nettype none

package epb_wb_pkg;

  // EPB side numbering is big-endian. Bit 0 is the most significant.
  typedef logic [5:29] epb_addr_t;     // Host word address bits.
  typedef logic [0:31] epb_data_t;
  typedef logic [0:3]  epb_be_t;       // Active low, lane 0 is the top byte.

  // Wishbone side numbering is little-endian.
  typedef logic [31:0] wb_addr_t;      // Byte address.
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  wb_sel_t;       // Active high, bit 3 is the top byte.

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_sel_t  sel;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    logic     err;
    wb_data_t dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    WB_WAIT,
    EPB_DONE
  } bridge_state_t;

  // Returned to the host on a bus error.
  localparam wb_data_t UNMAPPED_DATA = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

//--- verilog/epb_wb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module epb_wb_bridge (
  input  logic                  epb_clk,
  input  logic                  rst_n_i,
  input  logic                  epb_cs_n_i,
  input  logic                  epb_oe_n_i,
  input  logic                  epb_r_w_n_i,
  input  epb_wb_pkg::epb_be_t   epb_be_n_i,
  input  epb_wb_pkg::epb_addr_t epb_addr_i,
  input  epb_wb_pkg::epb_data_t epb_data_i,
  output epb_wb_pkg::epb_data_t epb_data_o,
  output logic                  epb_doen_o,
  output logic                  epb_rdy_o,
  output epb_wb_pkg::wb_req_t   wb_req_o,
  input  epb_wb_pkg::wb_rsp_t   wb_rsp_i
);

  epb_wb_pkg::bridge_state_t state_q;
  logic                      cs_n_q;    // Chip select seen on the previous edge.
  logic                      act_q;     // Drives cyc and stb.
  logic                      rdy_q;
  logic                      valid_q;   // Held read data is valid.
  logic                      we_q;
  epb_wb_pkg::wb_sel_t       sel_q;
  epb_wb_pkg::wb_addr_t      adr_q;
  epb_wb_pkg::wb_data_t      wdat_q;
  epb_wb_pkg::epb_data_t     rdat_q;
  logic                      start;
  logic                      done;

  // A new cycle needs a falling chip select.
  assign start = (state_q == epb_wb_pkg::IDLE) && !epb_cs_n_i && cs_n_q;
  assign done  = (state_q == epb_wb_pkg::WB_WAIT) && (wb_rsp_i.ack || wb_rsp_i.err);

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge epb_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= epb_wb_pkg::IDLE;
      cs_n_q  <= 1'b1;
      act_q   <= 1'b0;
      rdy_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      cs_n_q <= epb_cs_n_i;
      rdy_q  <= done;                       // One pulse per transaction.
      case (state_q)
        epb_wb_pkg::IDLE: begin
          if (start) begin
            act_q   <= 1'b1;
            state_q <= epb_wb_pkg::WB_WAIT;
          end
        end
        epb_wb_pkg::WB_WAIT: begin
          if (done) begin
            act_q   <= 1'b0;
            valid_q <= !we_q;
            state_q <= epb_wb_pkg::EPB_DONE;
          end
        end
        epb_wb_pkg::EPB_DONE: begin
          if (epb_cs_n_i) begin            // Host released the cycle.
            valid_q <= 1'b0;
            state_q <= epb_wb_pkg::IDLE;
          end
        end
        default: state_q <= epb_wb_pkg::IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Request capture and read data
  //////////////////////////////////////////////////

  // Packed assignments map EPB bit 0 onto Wishbone bit 31.
  always_ff @(posedge epb_clk) begin
    if (start) begin
      we_q   <= !epb_r_w_n_i;
      sel_q  <= ~epb_be_n_i;
      adr_q  <= {5'b0, epb_addr_i, 2'b00};
      wdat_q <= epb_data_i;
    end
    if (done && !we_q) begin
      rdat_q <= wb_rsp_i.err ? epb_wb_pkg::UNMAPPED_DATA : wb_rsp_i.dat;
    end
  end

  always_comb begin
    wb_req_o.cyc = act_q;
    wb_req_o.stb = act_q;
    wb_req_o.we  = we_q;
    wb_req_o.sel = sel_q;
    wb_req_o.adr = adr_q;
    wb_req_o.dat = wdat_q;
  end

  assign epb_data_o = rdat_q;
  assign epb_doen_o = valid_q && !epb_oe_n_i;
  assign epb_rdy_o  = rdy_q;

  rdy_single_a : assert property (@(posedge epb_clk) disable iff (!rst_n_i)
    epb_rdy_o |=> !epb_rdy_o);

endmodule

`default_nettype wire

//--- verilog/wb_slave_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb_slave_decoder #(
  parameter epb_wb_pkg::wb_addr_t SYS_BASE = 32'h0000_0000,
  parameter epb_wb_pkg::wb_addr_t SYS_HIGH = 32'h0000_00FF,
  parameter epb_wb_pkg::wb_addr_t RAM_BASE = 32'h0000_1000,
  parameter epb_wb_pkg::wb_addr_t RAM_HIGH = 32'h0000_13FF
) (
  input  logic                epb_clk,
  input  logic                rst_n_i,
  input  epb_wb_pkg::wb_req_t wbm_req_i,
  output epb_wb_pkg::wb_rsp_t wbm_rsp_o,
  output epb_wb_pkg::wb_req_t sys_req_o,
  input  epb_wb_pkg::wb_rsp_t sys_rsp_i,
  output epb_wb_pkg::wb_req_t ram_req_o,
  input  epb_wb_pkg::wb_rsp_t ram_rsp_i
);

  logic sys_hit;
  logic ram_hit;
  logic active;

  assign active  = wbm_req_i.cyc && wbm_req_i.stb;
  assign sys_hit = (wbm_req_i.adr >= SYS_BASE) && (wbm_req_i.adr <= SYS_HIGH);
  assign ram_hit = (wbm_req_i.adr >= RAM_BASE) && (wbm_req_i.adr <= RAM_HIGH);

  //////////////////////////////////////////////////
  // Request fan-out
  //////////////////////////////////////////////////

  // Shared fields go to both, strobes only to the hit.
  always_comb begin
    sys_req_o     = wbm_req_i;
    sys_req_o.cyc = wbm_req_i.cyc && sys_hit;
    sys_req_o.stb = wbm_req_i.stb && sys_hit;
    ram_req_o     = wbm_req_i;
    ram_req_o.cyc = wbm_req_i.cyc && ram_hit;
    ram_req_o.stb = wbm_req_i.stb && ram_hit;
  end

  //////////////////////////////////////////////////
  // Response mux
  //////////////////////////////////////////////////

  always_comb begin
    if (sys_hit) begin
      wbm_rsp_o = sys_rsp_i;
    end else if (ram_hit) begin
      wbm_rsp_o = ram_rsp_i;
    end else begin
      wbm_rsp_o.ack = 1'b0;
      wbm_rsp_o.err = active;            // Unmapped, fail at once.
      wbm_rsp_o.dat = epb_wb_pkg::UNMAPPED_DATA;
    end
  end

  one_slave_a : assert property (@(posedge epb_clk) disable iff (!rst_n_i)
    !(sys_req_o.cyc && ram_req_o.cyc));

  ack_xor_err_a : assert property (@(posedge epb_clk) disable iff (!rst_n_i)
    !(wbm_rsp_o.ack && wbm_rsp_o.err));

endmodule

`default_nettype wire

//--- verilog/sys_block.sv
`timescale 1ns/1ps
`default_nettype none

module sys_block #(
  parameter logic [31:0] BOARD_ID = 32'h0000_0000,
  parameter logic [7:0]  REV_MAJ  = 8'h00,
  parameter logic [7:0]  REV_MIN  = 8'h00,
  parameter logic [15:0] REV_RCS  = 16'h0000
) (
  input  logic                epb_clk,
  input  logic                rst_n_i,
  input  epb_wb_pkg::wb_req_t wb_req_i,
  output epb_wb_pkg::wb_rsp_t wb_rsp_o
);

  logic [5:0]           word;          // Word offset in a 256 byte window.
  logic                 access;
  logic                 ack_q;
  epb_wb_pkg::wb_data_t scratch_q;
  epb_wb_pkg::wb_data_t rd_data;
  epb_wb_pkg::wb_data_t dat_q;

  assign word   = wb_req_i.adr[7:2];
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  always_comb begin
    case (word)
      6'd0:    rd_data = BOARD_ID;
      6'd1:    rd_data = {REV_MAJ, REV_MIN, REV_RCS};
      6'd2:    rd_data = scratch_q;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge epb_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      scratch_q <= '0;
    end else begin
      ack_q <= access;
      // Only the scratch word is writable.
      if (access && wb_req_i.we && (word == 6'd2)) begin
        for (int b = 0; b < 4; b++) begin
          if (wb_req_i.sel[b]) begin
            scratch_q[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge epb_clk) begin
    if (access) begin
      dat_q <= rd_data;
    end
  end

  always_comb begin
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.err = 1'b0;
    wb_rsp_o.dat = dat_q;
  end

  ack_after_stb_a : assert property (@(posedge epb_clk) disable iff (!rst_n_i)
    wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

`default_nettype wire

//--- verilog/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                epb_clk,
  input  logic                rst_n_i,
  input  epb_wb_pkg::wb_req_t wb_req_i,
  output epb_wb_pkg::wb_rsp_t wb_rsp_o
);

  localparam int AW = $clog2(RAM_WORDS);

  epb_wb_pkg::wb_data_t mem [RAM_WORDS];
  epb_wb_pkg::wb_data_t dat_q;
  logic [AW-1:0]        idx;           // Wraps modulo the depth.
  logic                 access;
  logic                 ack_q;

  assign idx    = wb_req_i.adr[AW+1:2];
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  always_ff @(posedge epb_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge epb_clk) begin
    if (access && wb_req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_req_i.sel[b]) begin
          mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
        end
      end
    end
    dat_q <= mem[idx];
  end

  always_comb begin
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.err = 1'b0;
    wb_rsp_o.dat = dat_q;
  end

  ack_after_stb_a : assert property (@(posedge epb_clk) disable iff (!rst_n_i)
    wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

`default_nettype wire

//--- verilog/epb_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module epb_wb_top #(
  parameter logic [31:0]          BOARD_ID  = 32'h0000_0A01,
  parameter logic [7:0]           REV_MAJ   = 8'd1,
  parameter logic [7:0]           REV_MIN   = 8'd2,
  parameter logic [15:0]          REV_RCS   = 16'h0030,
  parameter int                   RAM_WORDS = 256,
  parameter epb_wb_pkg::wb_addr_t SYS_BASE  = 32'h0000_0000,
  parameter epb_wb_pkg::wb_addr_t SYS_HIGH  = 32'h0000_00FF,
  parameter epb_wb_pkg::wb_addr_t RAM_BASE  = 32'h0000_1000,
  parameter epb_wb_pkg::wb_addr_t RAM_HIGH  = 32'h0000_13FF
) (
  input  logic                  epb_clk,
  input  logic                  rst_n_i,
  input  logic                  epb_cs_n_i,
  input  logic                  epb_oe_n_i,
  input  logic                  epb_r_w_n_i,
  input  epb_wb_pkg::epb_be_t   epb_be_n_i,
  input  epb_wb_pkg::epb_addr_t epb_addr_i,
  input  epb_wb_pkg::epb_data_t epb_data_i,
  output epb_wb_pkg::epb_data_t epb_data_o,
  output logic                  epb_doen_o,    // Pad driver enable.
  output logic                  epb_rdy_o
);

  epb_wb_pkg::wb_req_t wb_req;
  epb_wb_pkg::wb_rsp_t wb_rsp;
  epb_wb_pkg::wb_req_t sys_req;
  epb_wb_pkg::wb_rsp_t sys_rsp;
  epb_wb_pkg::wb_req_t ram_req;
  epb_wb_pkg::wb_rsp_t ram_rsp;

  //////////////////////////////////////////////////
  // Bus master and address decode
  //////////////////////////////////////////////////

  epb_wb_bridge i_bridge (
    .epb_clk     (epb_clk),
    .rst_n_i     (rst_n_i),
    .epb_cs_n_i  (epb_cs_n_i),
    .epb_oe_n_i  (epb_oe_n_i),
    .epb_r_w_n_i (epb_r_w_n_i),
    .epb_be_n_i  (epb_be_n_i),
    .epb_addr_i  (epb_addr_i),
    .epb_data_i  (epb_data_i),
    .epb_data_o  (epb_data_o),
    .epb_doen_o  (epb_doen_o),
    .epb_rdy_o   (epb_rdy_o),
    .wb_req_o    (wb_req),
    .wb_rsp_i    (wb_rsp)
  );

  wb_slave_decoder #(
    .SYS_BASE (SYS_BASE),
    .SYS_HIGH (SYS_HIGH),
    .RAM_BASE (RAM_BASE),
    .RAM_HIGH (RAM_HIGH)
  ) i_decoder (
    .epb_clk   (epb_clk),
    .rst_n_i   (rst_n_i),
    .wbm_req_i (wb_req),
    .wbm_rsp_o (wb_rsp),
    .sys_req_o (sys_req),
    .sys_rsp_i (sys_rsp),
    .ram_req_o (ram_req),
    .ram_rsp_i (ram_rsp)
  );

  //////////////////////////////////////////////////
  // Slaves
  //////////////////////////////////////////////////

  sys_block #(
    .BOARD_ID (BOARD_ID),
    .REV_MAJ  (REV_MAJ),
    .REV_MIN  (REV_MIN),
    .REV_RCS  (REV_RCS)
  ) i_sys (
    .epb_clk  (epb_clk),
    .rst_n_i  (rst_n_i),
    .wb_req_i (sys_req),
    .wb_rsp_o (sys_rsp)
  );

  scratch_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) i_ram (
    .epb_clk  (epb_clk),
    .rst_n_i  (rst_n_i),
    .wb_req_i (ram_req),
    .wb_rsp_o (ram_rsp)
  );

endmodule

`default_nettype wire

//--- bench/epb_wb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module epb_wb_checker (
  input  logic        epb_clk,
  input  logic        rst_n_i,
  input  logic        epb_cs_n_i,
  input  logic        epb_oe_n_i,
  input  logic [31:0] dut_data_i,
  input  logic        dut_doen_i,
  input  logic        dut_rdy_i,
  input  logic [31:0] exp_data_i,
  input  logic        exp_read_i,
  input  logic        exp_unmapped_i,
  input  int          exp_entry_i,
  output int          check_cnt_o,
  output int          error_cnt_o
);

  logic cs_n_prev;
  logic rdy_prev;
  logic read_held;     // Read data should be on the pins.
  int   since_start;   // Edges since the start sample.
  int   exp_lat;
  int   checks = 0;
  int   errors = 0;

  assign check_cnt_o = checks;
  assign error_cnt_o = errors;

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
  endtask

  // A cycle starts on the first edge that samples cs_n low after high.
  always @(posedge epb_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cs_n_prev   <= 1'b1;
      since_start <= 0;
    end else begin
      cs_n_prev <= epb_cs_n_i;
      if (!epb_cs_n_i && cs_n_prev) begin
        since_start <= 0;
      end else if (since_start < 1000) begin
        since_start <= since_start + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Mid-cycle checks
  //////////////////////////////////////////////////

  always @(negedge epb_clk) begin
    if (!rst_n_i) begin
      rdy_prev  = 1'b0;
      read_held = 1'b0;
    end else begin
      if (dut_rdy_i) begin
        exp_lat = exp_unmapped_i ? 1 : 2;   // Err answers one edge sooner.
        checks++;
        if (rdy_prev) begin
          flag_mismatch($sformatf("entry %0d ready high for two cycles", exp_entry_i));
        end
        if (since_start != exp_lat) begin
          flag_mismatch($sformatf("entry %0d ready %0d edges after start, expected %0d",
                                  exp_entry_i, since_start, exp_lat));
        end
        if (exp_read_i) begin
          checks++;
          read_held = 1'b1;
          if (dut_data_i !== exp_data_i) begin
            flag_mismatch($sformatf("entry %0d read data %h, expected %h",
                                    exp_entry_i, dut_data_i, exp_data_i));
          end
        end
      end
      if (epb_cs_n_i) read_held = 1'b0;
      if (dut_doen_i !== (read_held && !epb_oe_n_i)) begin
        flag_mismatch($sformatf("data enable is %b, expected %b", dut_doen_i,
                                read_held && !epb_oe_n_i));
      end
      if (epb_cs_n_i && dut_rdy_i) flag_mismatch("ready high while chip select is high");
      rdy_prev = dut_rdy_i;
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_epb_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_epb_wb;

  typedef struct packed {
    logic        wr;
    logic [24:0] addr;       // EPB word address.
    logic [3:0]  be_n;       // Leftmost bit is lane 0.
    logic [31:0] wdata;
    logic        rnd;        // Write data or expectation from the random model.
    logic [31:0] exp_data;
    logic        unmapped;
  } stim_t;

  localparam int          RDY_LIMIT = 8;
  localparam logic [31:0] BOARD_ID  = 32'h0000_0A01;
  localparam logic [31:0] REV_WORD  = 32'h0102_0030;
  localparam logic [31:0] ALL_ONES  = 32'hFFFF_FFFF;

  logic        epb_clk;
  logic        rst_n;
  logic        epb_cs_n;
  logic        epb_oe_n;
  logic        epb_r_w_n;
  logic [3:0]  epb_be_n;
  logic [24:0] epb_addr;
  logic [31:0] epb_wdata;
  logic [31:0] epb_rdata;
  logic        epb_doen;
  logic        epb_rdy;
  logic [31:0] exp_data;
  logic        exp_read;
  logic        exp_unmapped;
  int          exp_entry;
  int          check_cnt;
  int          error_cnt;
  int          tb_errors;
  stim_t       stim_q [$];
  logic [31:0] rnd_model [logic [24:0]];

  epb_wb_top i_dut (
    .epb_clk     (epb_clk),
    .rst_n_i     (rst_n),
    .epb_cs_n_i  (epb_cs_n),
    .epb_oe_n_i  (epb_oe_n),
    .epb_r_w_n_i (epb_r_w_n),
    .epb_be_n_i  (epb_be_n),
    .epb_addr_i  (epb_addr),
    .epb_data_i  (epb_wdata),
    .epb_data_o  (epb_rdata),
    .epb_doen_o  (epb_doen),
    .epb_rdy_o   (epb_rdy)
  );

  epb_wb_checker i_checker (
    .epb_clk        (epb_clk),
    .rst_n_i        (rst_n),
    .epb_cs_n_i     (epb_cs_n),
    .epb_oe_n_i     (epb_oe_n),
    .dut_data_i     (epb_rdata),
    .dut_doen_i     (epb_doen),
    .dut_rdy_i      (epb_rdy),
    .exp_data_i     (exp_data),
    .exp_read_i     (exp_read),
    .exp_unmapped_i (exp_unmapped),
    .exp_entry_i    (exp_entry),
    .check_cnt_o    (check_cnt),
    .error_cnt_o    (error_cnt)
  );

  initial begin
    epb_clk = 1'b0;
    forever #5 epb_clk = ~epb_clk;
  end

  initial begin : watchdog
    @(posedge rst_n);
    repeat (stim_q.size() * 20 + 100) @(posedge epb_clk);
    $display("Watchdog timeout: run exceeded %0d cycles", stim_q.size() * 20 + 100);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be_n);
    logic [31:0] res;
    res = old_w;
    for (int lane = 0; lane < 4; lane++) begin
      if (!be_n[3-lane]) begin
        res[31-8*lane -: 8] = new_w[31-8*lane -: 8];   // Lane 0 is the top byte.
      end
    end
    return res;
  endfunction

  function automatic void add_entry(logic wr, logic [24:0] addr, logic [3:0] be_n,
                                    logic [31:0] wdata, logic rnd, logic [31:0] exp_w,
                                    logic unmapped);
    stim_q.push_back(stim_t'({wr, addr, be_n, wdata, rnd, exp_w, unmapped}));
  endfunction

  //////////////////////////////////////////////////
  // One EPB cycle per table entry
  //////////////////////////////////////////////////

  task automatic run_entry(input int n);
    stim_t       e;
    logic [31:0] wdata;
    logic [31:0] exp_w;
    int          waited;
    e     = stim_q[n];
    wdata = e.wdata;
    exp_w = e.exp_data;
    if (e.rnd && e.wr) begin
      wdata = $urandom();
      rnd_model[e.addr] = merge_bytes(rnd_model.exists(e.addr) ? rnd_model[e.addr] : 32'h0,
                                      wdata, e.be_n);
    end else if (e.rnd) begin
      exp_w = rnd_model[e.addr];
    end
    @(posedge epb_clk);
    #1;
    epb_cs_n  = 1'b0;
    epb_oe_n  = e.wr;          // Output enable only on reads.
    epb_r_w_n = !e.wr;
    epb_be_n  = e.be_n;
    epb_addr  = e.addr;
    epb_wdata = wdata;
    waited    = 0;
    do begin
      @(posedge epb_clk);
      #1;
      waited++;
    end while (!epb_rdy && waited < RDY_LIMIT);
    if (!epb_rdy) begin
      tb_errors++;
      $display("Entry %0d got no ready from the DUT within %0d cycles", n, waited);
    end
    exp_data     = exp_w;
    exp_read     = !e.wr;
    exp_unmapped = e.unmapped;
    exp_entry    = n;
    @(posedge epb_clk);
    #1;
    epb_cs_n = 1'b1;
    epb_oe_n = 1'b1;
    @(posedge epb_clk);        // Idle cycle.
  endtask

  initial begin
    void'($urandom(32'hbcaf1aab));
    rst_n        = 1'b0;
    epb_cs_n     = 1'b1;
    epb_oe_n     = 1'b1;
    epb_r_w_n    = 1'b1;
    epb_be_n     = 4'hF;
    epb_addr     = '0;
    epb_wdata    = '0;
    exp_data     = '0;
    exp_read     = 1'b0;
    exp_unmapped = 1'b0;
    exp_entry    = 0;
    tb_errors    = 0;
    // wr, word, be_n, data, rnd, expected, unmapped
    add_entry(1'b0, 25'h000, 4'h0, 32'h0, 1'b0, BOARD_ID, 1'b0);
    add_entry(1'b0, 25'h001, 4'h0, 32'h0, 1'b0, REV_WORD, 1'b0);
    add_entry(1'b1, 25'h000, 4'h0, 32'hDEAD_BEEF, 1'b0, 32'h0, 1'b0);
    add_entry(1'b0, 25'h000, 4'h0, 32'h0, 1'b0, BOARD_ID, 1'b0);
    add_entry(1'b0, 25'h002, 4'h0, 32'h0, 1'b0, 32'h0, 1'b0);
    add_entry(1'b1, 25'h002, 4'h0, 32'h1234_5678, 1'b0, 32'h0, 1'b0);
    add_entry(1'b0, 25'h002, 4'h0, 32'h0, 1'b0, 32'h1234_5678, 1'b0);
    add_entry(1'b1, 25'h002, 4'b0111, 32'hAABB_CCDD, 1'b0, 32'h0, 1'b0);
    add_entry(1'b0, 25'h002, 4'h0, 32'h0, 1'b0, 32'hAA34_5678, 1'b0);
    add_entry(1'b1, 25'h002, 4'b1010, 32'h1122_3344, 1'b0, 32'h0, 1'b0);
    add_entry(1'b0, 25'h002, 4'h0, 32'h0, 1'b0, 32'hAA22_5644, 1'b0);
    add_entry(1'b0, 25'h003, 4'h0, 32'h0, 1'b0, 32'h0, 1'b0);
    add_entry(1'b1, 25'h400, 4'h0, 32'h0, 1'b1, 32'h0, 1'b0);
    add_entry(1'b1, 25'h4FF, 4'h0, 32'h0, 1'b1, 32'h0, 1'b0);
    add_entry(1'b1, 25'h47A, 4'h0, 32'h0, 1'b1, 32'h0, 1'b0);
    add_entry(1'b0, 25'h400, 4'h0, 32'h0, 1'b1, 32'h0, 1'b0);
    add_entry(1'b0, 25'h4FF, 4'h0, 32'h0, 1'b1, 32'h0, 1'b0);
    add_entry(1'b1, 25'h47A, 4'b1100, 32'h0, 1'b1, 32'h0, 1'b0);
    add_entry(1'b0, 25'h47A, 4'h0, 32'h0, 1'b1, 32'h0, 1'b0);
    add_entry(1'b0, 25'h100, 4'h0, 32'h0, 1'b0, ALL_ONES, 1'b1);
    add_entry(1'b0, 25'h500, 4'h0, 32'h0, 1'b0, ALL_ONES, 1'b1);
    add_entry(1'b1, 25'h102, 4'h0, 32'h5555_5555, 1'b0, 32'h0, 1'b1);
    add_entry(1'b1, 25'h500, 4'h0, 32'h6666_6666, 1'b0, 32'h0, 1'b1);
    add_entry(1'b0, 25'h400, 4'h0, 32'h0, 1'b1, 32'h0, 1'b0);
    add_entry(1'b0, 25'h002, 4'h0, 32'h0, 1'b0, 32'hAA22_5644, 1'b0);
    repeat (5) @(posedge epb_clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge epb_clk);   // Quiet bus after reset.
    for (int n = 0; n < stim_q.size(); n++) begin
      run_entry(n);
    end
    $display("Checks: %0d  checker errors: %0d  testbench errors: %0d",
             check_cnt, error_cnt, tb_errors);
    if (error_cnt == 0 && tb_errors == 0 && check_cnt > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- epb_wb.f
verilog/epb_wb_pkg.sv
verilog/epb_wb_bridge.sv
verilog/wb_slave_decoder.sv
verilog/sys_block.sv
verilog/scratch_ram.sv
verilog/epb_wb_top.sv
bench/epb_wb_checker.sv
bench/tb_epb_wb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_epb_wb
FILELIST  := epb_wb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
